/* sap_cpu.f */
+incdir+dv
verilog/sap_isa_pkg.sv
verilog/sap_ctrl_pkg.sv
verilog/program_counter.sv
verilog/control_block.sv
verilog/program_memory.sv
verilog/alu_datapath.sv
verilog/bus_arbiter.sv
verilog/sap_cpu_top.sv
dv/tb_sap_cpu.sv

/* Makefile */
TOP := tb_sap_cpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sap_cpu.f --top-module $(TOP) -Mdir obj_dir

run: build
	obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then echo "no result in sim.log"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f sap_cpu.f --top-module sap_cpu_top

clean:
	rm -rf obj_dir sim.log

/* dv/tb_sap_programs.svh */
// every instruction spends five cycles, T0 to T4
localparam int cycles_per_instr = 5;
// upper bound for any program to reach HLT
localparam int halt_timeout = 400;

// unused words hold HLT with their own address as operand

// LDA E, ADD F, OUT, HLT with data C8 and 5A at E and F
localparam logic [data_w-1:0] prog_add_image [mem_depth] = '{
    8'h1E, 8'h2F, 8'hE0, 8'hF0, 8'hF4, 8'hF5, 8'hF6, 8'hF7,
    8'hF8, 8'hF9, 8'hFA, 8'hFB, 8'hFC, 8'hFD, 8'hC8, 8'h5A
};

// LDI 5, SUB F, OUT, HLT; word F gets the random operand
localparam logic [data_w-1:0] prog_sub_image [mem_depth] = '{
    8'h55, 8'h3F, 8'hE0, 8'hF0, 8'hF4, 8'hF5, 8'hF6, 8'hF7,
    8'hF8, 8'hF9, 8'hFA, 8'hFB, 8'hFC, 8'hFD, 8'hFE, 8'h00
};

// LDA E, STA D, LDI 0, LDA D, OUT, HLT; D starts clear
localparam logic [data_w-1:0] prog_store_image [mem_depth] = '{
    8'h1E, 8'h4D, 8'h50, 8'h1D, 8'hE0, 8'hF0, 8'hF6, 8'hF7,
    8'hF8, 8'hF9, 8'hFA, 8'hFB, 8'hFC, 8'h00, 8'hA7, 8'hFF
};

// countdown from E by F with OUT, SUB, JZ 5, JMP 1
// then ADD D (no carry), JC 9 not taken, ADD C (carry), JC A taken, OUT, HLT
localparam logic [data_w-1:0] prog_count_image [mem_depth] = '{
    8'h1E, 8'hE0, 8'h3F, 8'h85, 8'h61, 8'h2D, 8'h79, 8'h2C,
    8'h7A, 8'hF0, 8'hE0, 8'hF0, 8'h20, 8'hF0, 8'h03, 8'h01
};

// LDI 9, OUT, NOP, OUT, HLT
localparam logic [data_w-1:0] prog_gap_image [mem_depth] = '{
    8'h59, 8'hE0, 8'h00, 8'hE0, 8'hF0, 8'hF5, 8'hF6, 8'hF7,
    8'hF8, 8'hF9, 8'hFA, 8'hFB, 8'hFC, 8'hFD, 8'hFE, 8'hFF
};

// LDI 6, OUT, HLT, then two OUT that never execute
localparam logic [data_w-1:0] prog_halt_image [mem_depth] = '{
    8'h56, 8'hE0, 8'hF0, 8'hE0, 8'hE0, 8'hF5, 8'hF6, 8'hF7,
    8'hF8, 8'hF9, 8'hFA, 8'hFB, 8'hFC, 8'hFD, 8'hFE, 8'hFF
};

/* dv/tb_sap_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sap_cpu
    import sap_isa_pkg::*;
();

    `include "tb_sap_programs.svh"

    logic              clk;
    logic              rst;
    logic              run;
    logic              prog_we;
    logic [addr_w-1:0] prog_addr;
    logic [data_w-1:0] prog_data;
    logic [data_w-1:0] out_data;
    logic              out_valid;
    logic              halted;

    // image written through the load port
    logic [data_w-1:0] image_buf [mem_depth];

    // expected and collected output sequences
    logic [data_w-1:0] exp_q [$];
    logic [data_w-1:0] got_q [$];

    // negedge samples stay stable for the assertions at the next rising edge
    logic              got_fresh;
    logic              got_in_range;
    logic [data_w-1:0] got_last;
    logic [data_w-1:0] exp_last;
    int                got_index;
    int                got_gap;
    int                last_valid_cycle;
    int                cycle_count;
    logic              halted_s;
    logic              halted_prev;
    logic              valid_s;

    // check strobes raised by the test sequence
    logic              count_check;
    logic              reset_check;
    logic              gap_check;
    int                got_count;
    int                exp_count;
    int                exp_gap;

    string             test_name;
    int                error_count;
    int                errors_at_start;
    int                tests_run;
    int                tests_failed;
    integer            seed;

    sap_cpu_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // record one out_valid pulse with its expected value and spacing
    task automatic collect_output();
        got_fresh = 1'b0;
        if (out_valid) begin
            got_index        = got_q.size();
            got_in_range     = (got_index < exp_q.size());
            exp_last         = got_in_range ? exp_q[got_index] : '0;
            got_gap          = cycle_count - last_valid_cycle;
            last_valid_cycle = cycle_count;
            got_last         = out_data;
            got_fresh        = 1'b1;
            got_q.push_back(out_data);
        end
    endtask

    // DUT outputs move at the rising edge and are sampled mid-cycle
    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        halted_prev = halted_s;
        halted_s    = halted;
        valid_s     = out_valid;
        collect_output();
    end

    // each output against the sequence from the ISA rules
    assert property (@(posedge clk) got_fresh && got_in_range |-> got_last == exp_last)
        else begin
            $display("Error: test %s output %0d expected 0x%02h actual 0x%02h",
                     test_name, got_index, exp_last, got_last);
            error_count++;
        end

    assert property (@(posedge clk) got_fresh |-> got_in_range)
        else begin
            $display("test %s: out_valid pulsed more often than the program outputs",
                     test_name);
            error_count++;
        end

    // pulse spacing only where the test arms it
    assert property (@(posedge clk) got_fresh && gap_check && got_index > 0 |->
                     got_gap == exp_gap)
        else begin
            $display("Error: test %s out_valid spacing expected %0d actual %0d",
                     test_name, exp_gap, got_gap);
            error_count++;
        end

    assert property (@(posedge clk) count_check |-> got_count == exp_count)
        else begin
            $display("Error: test %s output count expected %0d actual %0d",
                     test_name, exp_count, got_count);
            error_count++;
        end

    assert property (@(posedge clk) disable iff (rst) halted_s |-> !valid_s)
        else begin
            $display("test %s: out_valid pulsed while halted", test_name);
            error_count++;
        end

    // halted is sticky until reset
    assert property (@(posedge clk) disable iff (rst) halted_prev |-> halted_s)
        else begin
            $display("test %s: halted dropped without a reset", test_name);
            error_count++;
        end

    assert property (@(posedge clk) reset_check |-> !halted_s && !valid_s)
        else begin
            $display("test %s: reset did not clear halted and out_valid", test_name);
            error_count++;
        end

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst     = 1'b1;
        run     = 1'b0;
        prog_we = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // one word per cycle while run stays low
    task automatic load_image();
        int a;
        run = 1'b0;
        for (a = 0; a < mem_depth; a++) begin
            @(posedge clk);
            #1;
            prog_we   = 1'b1;
            prog_addr = addr_w'(a);
            prog_data = image_buf[a];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        #1;
        run = 1'b1;
    endtask

    task automatic wait_halted();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
            done = halted;
        end
        if (!done) begin
            $display("timeout: halted did not rise within %0d cycles in test %s",
                     halt_timeout, test_name);
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        gap_check       = 1'b0;
        exp_q.delete();
        got_q.delete();
        tests_run++;
    endtask

    // stop the CPU and compare the number of outputs
    task automatic check_count();
        @(posedge clk);
        #1;
        run         = 1'b0;
        got_count   = got_q.size();
        exp_count   = exp_q.size();
        count_check = 1'b1;
        @(posedge clk);
        #1;
        count_check = 1'b0;
    endtask

    task automatic report_test();
        if (error_count == errors_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name,
                     error_count - errors_at_start);
        end
    endtask

    task automatic run_program();
        start_run();
        wait_halted();
        check_count();
    endtask

    initial begin
        int                rand_word;
        logic [addr_w-1:0] rand_op;
        logic [data_w-1:0] value;
        clk              = 1'b0;
        rst              = 1'b1;
        run              = 1'b0;
        prog_we          = 1'b0;
        prog_addr        = '0;
        prog_data        = '0;
        got_fresh        = 1'b0;
        got_in_range     = 1'b0;
        got_last         = '0;
        exp_last         = '0;
        got_index        = 0;
        got_gap          = 0;
        last_valid_cycle = 0;
        cycle_count      = 0;
        halted_s         = 1'b0;
        halted_prev      = 1'b0;
        valid_s          = 1'b0;
        count_check      = 1'b0;
        reset_check      = 1'b0;
        gap_check        = 1'b0;
        got_count        = 0;
        exp_count        = 0;
        exp_gap          = 0;
        error_count      = 0;
        errors_at_start  = 0;
        tests_run        = 0;
        tests_failed     = 0;
        seed             = 32'h94c0_2b6e;

        // sum of two stored bytes modulo 256
        begin_test("add");
        reset_dut();
        image_buf = prog_add_image;
        load_image();
        value = image_buf[14] + image_buf[15];
        exp_q.push_back(value);
        run_program();
        report_test();

        // immediate minus a random 4-bit byte with wrap on borrow
        begin_test("sub");
        reset_dut();
        rand_word     = $random(seed);
        rand_op       = addr_w'(rand_word);
        // top bit set so the operand exceeds the immediate and the SUB borrows
        rand_op[addr_w-1] = 1'b1;
        image_buf     = prog_sub_image;
        image_buf[15] = {4'h0, rand_op};
        load_image();
        value = {4'h0, image_buf[0][3:0]} - {4'h0, rand_op};
        exp_q.push_back(value);
        run_program();
        report_test();

        // stored accumulator reads back unchanged
        begin_test("store");
        reset_dut();
        image_buf = prog_store_image;
        load_image();
        exp_q.push_back(image_buf[14]);
        run_program();
        report_test();

        // descending values until the difference is zero
        begin_test("countdown");
        reset_dut();
        image_buf = prog_count_image;
        load_image();
        value = image_buf[14];
        while (value != '0) begin
            exp_q.push_back(value);
            value = value - image_buf[15];
        end
        // accumulator is zero on JZ exit and the second of two adds overflows
        value = image_buf[13] + image_buf[12];
        exp_q.push_back(value);
        run_program();
        report_test();

        // two OUT with a NOP between are two instructions apart
        begin_test("gap");
        reset_dut();
        image_buf = prog_gap_image;
        load_image();
        value = {4'h0, image_buf[0][3:0]};
        exp_q.push_back(value);
        exp_q.push_back(value);
        exp_gap   = 2 * cycles_per_instr;
        gap_check = 1'b1;
        run_program();
        report_test();

        // halted stays high and silent until a reset clears it
        begin_test("halt");
        reset_dut();
        image_buf = prog_halt_image;
        load_image();
        value = {4'h0, image_buf[0][3:0]};
        exp_q.push_back(value);
        start_run();
        wait_halted();
        // run stays high while halted
        repeat (20) @(posedge clk);
        check_count();
        reset_dut();
        reset_check = 1'b1;
        @(posedge clk);
        #1;
        reset_check = 1'b0;
        report_test();

        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/sap_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sap_cpu_top
    import sap_isa_pkg::*;
    import sap_ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              run,
    input  wire logic              prog_we,
    input  wire logic [addr_w-1:0] prog_addr,
    input  wire logic [data_w-1:0] prog_data,
    output logic [data_w-1:0]      out_data,
    output logic                   out_valid,
    output logic                   halted
);

    // shared internal bus and the control word
    logic [data_w-1:0] bus;
    ctrl_word_t        ctrl;

    // bus source candidates
    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] ir_operand;
    mem_word_u         mem_word;
    logic [data_w-1:0] acc;
    logic [data_w-1:0] alu_result;

    // flags for the conditional jumps
    logic              carry;
    logic              zero;

    program_counter i_pc (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl),
        .bus  (bus),
        .pc   (pc)
    );

    control_block i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .bus        (bus),
        .carry      (carry),
        .zero       (zero),
        .ir_operand (ir_operand),
        .ctrl       (ctrl),
        .halted     (halted)
    );

    program_memory i_mem (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .bus       (bus),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .mem_word  (mem_word)
    );

    alu_datapath i_alu (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .bus        (bus),
        .acc        (acc),
        .alu_result (alu_result),
        .carry      (carry),
        .zero       (zero),
        .out_data   (out_data),
        .out_valid  (out_valid)
    );

    bus_arbiter i_arb (
        .ctrl       (ctrl),
        .pc         (pc),
        .mem_word   (mem_word),
        .ir_operand (ir_operand),
        .acc        (acc),
        .alu_result (alu_result),
        .bus        (bus)
    );

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import sap_isa_pkg::*;
    import sap_ctrl_pkg::*;
(
    input  wire ctrl_word_t        ctrl,
    input  wire logic [addr_w-1:0] pc,
    input  wire mem_word_u         mem_word,
    input  wire logic [addr_w-1:0] ir_operand,
    input  wire logic [data_w-1:0] acc,
    input  wire logic [data_w-1:0] alu_result,
    output logic [data_w-1:0]      bus
);

    logic bus_reader;

    // every field that samples the bus at the clock edge
    assign bus_reader = ctrl.pc_load | ctrl.mar_load | ctrl.mem_write | ctrl.ir_load |
                        ctrl.acc_load | ctrl.b_load | ctrl.out_load;

    // one driver per cycle, zero when idle
    always_comb begin
        case (ctrl.bus_src)
            PC:         bus = {{(data_w-addr_w){1'b0}}, pc};
            MEM:        bus = mem_word.data;
            IR_OPERAND: bus = {{(data_w-addr_w){1'b0}}, ir_operand};
            ACC:        bus = acc;
            ALU:        bus = alu_result;
            default:    bus = '0;
        endcase
    end

    // a block never loads from an undriven bus
    always_comb begin
        assert final (!(bus_reader && ctrl.bus_src == NONE));
    end

endmodule

`default_nettype wire

/* verilog/alu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_datapath
    import sap_isa_pkg::*;
    import sap_ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire ctrl_word_t        ctrl,
    input  wire logic [data_w-1:0] bus,
    output logic [data_w-1:0]      acc,
    output logic [data_w-1:0]      alu_result,
    output logic                   carry,
    output logic                   zero,
    output logic [data_w-1:0]      out_data,
    output logic                   out_valid
);

    logic [data_w-1:0] b_reg;
    logic [data_w-1:0] b_operand;
    logic [data_w:0]   sum;

    // subtract as acc + ~b + 1, so the carry out means no borrow
    assign b_operand  = ctrl.alu_sub ? ~b_reg : b_reg;
    assign sum        = {1'b0, acc} + {1'b0, b_operand} + {{data_w{1'b0}}, ctrl.alu_sub};
    assign alu_result = sum[data_w-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            b_reg     <= '0;
            carry     <= 1'b0;
            zero      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (ctrl.acc_load) begin
                acc <= bus;
            end
            if (ctrl.b_load) begin
                b_reg <= bus;
            end
            // flags move only on ADD and SUB
            if (ctrl.flags_load) begin
                carry <= sum[data_w];
                zero  <= (alu_result == '0);
            end
            // valid one cycle after the OUT T2
            out_valid <= ctrl.out_load;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (ctrl.out_load) begin
            out_data <= bus;
        end
    end

    // an OUT spans five T-states, so valid never lasts two cycles
    assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid);

endmodule

`default_nettype wire

/* verilog/program_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module program_memory
    import sap_isa_pkg::*;
    import sap_ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire ctrl_word_t        ctrl,
    input  wire logic [data_w-1:0] bus,
    input  wire logic              prog_we,
    input  wire logic [addr_w-1:0] prog_addr,
    input  wire logic [data_w-1:0] prog_data,
    output mem_word_u              mem_word
);

    logic [addr_w-1:0] mar;
    mem_word_u         mem [mem_depth];

    // memory address register, from the PC at T0 or the operand at T2
    always_ff @(posedge clk) begin
        if (rst) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= bus[addr_w-1:0];
        end
    end

    // load port writes while stopped, STA writes while running
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr].data <= prog_data;
        end else if (ctrl.mem_write) begin
            mem[mar].data <= bus;
        end
    end

    // asynchronous read at the MAR
    assign mem_word = mem[mar];

    // program loading and STA must never collide
    assert property (@(posedge clk) disable iff (rst)
        !(prog_we && ctrl.mem_write));

endmodule

`default_nettype wire

/* verilog/control_block.sv */
`timescale 1ns/1ps
`default_nettype none

module control_block
    import sap_isa_pkg::*;
    import sap_ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              run,
    input  wire logic [data_w-1:0] bus,
    input  wire logic              carry,
    input  wire logic              zero,
    output logic [addr_w-1:0]      ir_operand,
    output ctrl_word_t             ctrl,
    output logic                   halted
);

    instr_t    ir;
    tstate_t   tstate;
    logic      run_en;
    mem_word_u fetched;

    // sequencing only while running and not halted
    assign run_en = run && !halted;

    // the memory word on the bus seen as an instruction
    assign fetched.data = bus;

    // instruction register filled at the end of T1
    always_ff @(posedge clk) begin
        if (ctrl.ir_load) begin
            ir <= fetched.instr;
        end
    end

    assign ir_operand = ir.operand;

    // ring counter where T4 wraps back to T0
    always_ff @(posedge clk) begin
        if (rst) begin
            tstate <= T0;
        end else if (run_en) begin
            tstate <= tstate_t'({tstate[t_states-2:0], tstate[t_states-1]});
        end
    end

    // sticky until the next reset
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (ctrl.halt) begin
            halted <= 1'b1;
        end
    end

    // microcode decode
    always_comb begin
        ctrl = ctrl_idle;
        case (tstate)
            // PC address into the MAR
            T0: begin
                ctrl.bus_src  = PC;
                ctrl.mar_load = 1'b1;
            end
            // fetched word into the IR while the PC steps
            T1: begin
                ctrl.bus_src = MEM;
                ctrl.ir_load = 1'b1;
                ctrl.pc_inc  = 1'b1;
            end
            T2: begin
                case (ir.opcode)
                    LDA, ADD, SUB, STA: begin
                        ctrl.bus_src  = IR_OPERAND;
                        ctrl.mar_load = 1'b1;
                    end
                    // immediate straight into the accumulator
                    LDI: begin
                        ctrl.bus_src  = IR_OPERAND;
                        ctrl.acc_load = 1'b1;
                    end
                    JMP: begin
                        ctrl.bus_src = IR_OPERAND;
                        ctrl.pc_load = 1'b1;
                    end
                    // conditional jumps fall through as NOP when the flag is clear
                    JC: begin
                        if (carry) begin
                            ctrl.bus_src = IR_OPERAND;
                            ctrl.pc_load = 1'b1;
                        end
                    end
                    JZ: begin
                        if (zero) begin
                            ctrl.bus_src = IR_OPERAND;
                            ctrl.pc_load = 1'b1;
                        end
                    end
                    OUT: begin
                        ctrl.bus_src  = ACC;
                        ctrl.out_load = 1'b1;
                    end
                    HLT: begin
                        ctrl.halt = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            T3: begin
                case (ir.opcode)
                    LDA: begin
                        ctrl.bus_src  = MEM;
                        ctrl.acc_load = 1'b1;
                    end
                    // second operand parks in B
                    ADD, SUB: begin
                        ctrl.bus_src = MEM;
                        ctrl.b_load  = 1'b1;
                    end
                    STA: begin
                        ctrl.bus_src   = ACC;
                        ctrl.mem_write = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            T4: begin
                // result back into the accumulator together with the flags
                if (ir.opcode == ADD || ir.opcode == SUB) begin
                    ctrl.bus_src    = ALU;
                    ctrl.acc_load   = 1'b1;
                    ctrl.flags_load = 1'b1;
                    ctrl.alu_sub    = (ir.opcode == SUB);
                end
            end
            default: begin
            end
        endcase
        // stopped, halted or resetting CPU issues no loads
        if (!run_en || rst) begin
            ctrl = ctrl_idle;
        end
    end

    // ring must hold exactly one token
    assert property (@(posedge clk) disable iff (rst) $onehot(tstate));

endmodule

`default_nettype wire

/* verilog/program_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module program_counter
    import sap_isa_pkg::*;
    import sap_ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire ctrl_word_t        ctrl,
    input  wire logic [data_w-1:0] bus,
    output logic [addr_w-1:0]      pc
);

    // jump target comes from the low nibble of the bus
    // increment wraps 15 -> 0 by width
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= bus[addr_w-1:0];
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // fetch increments at T1, jumps load at T2, never in the same cycle
    assert property (@(posedge clk) disable iff (rst)
        !(ctrl.pc_inc && ctrl.pc_load));

endmodule

`default_nettype wire

/* verilog/sap_ctrl_pkg.sv */
`default_nettype none

package sap_ctrl_pkg;

    // five T-states per instruction
    localparam int t_states = 5;

    // who drives the internal bus this cycle
    typedef enum logic [2:0] {
        NONE,
        PC,
        MEM,
        IR_OPERAND,
        ACC,
        ALU
    } bus_src_t;

    // one-hot ring, one bit per T-state
    typedef enum logic [t_states-1:0] {
        T0 = 5'b00001,
        T1 = 5'b00010,
        T2 = 5'b00100,
        T3 = 5'b01000,
        T4 = 5'b10000
    } tstate_t;

    typedef struct packed {
        bus_src_t bus_src;
        logic     pc_inc;
        logic     pc_load;
        logic     mar_load;
        logic     mem_write;
        logic     ir_load;
        logic     acc_load;
        logic     b_load;
        logic     alu_sub;
        logic     flags_load;
        logic     out_load;
        logic     halt;
    } ctrl_word_t;

    // nothing on the bus, nothing loads
    localparam ctrl_word_t ctrl_idle = '0;

endpackage

`default_nettype wire

/* verilog/sap_isa_pkg.sv */
`default_nettype none

package sap_isa_pkg;

    // data byte and address nibble, fixed by the 8-bit instruction format
    localparam int data_w = 8;
    localparam int addr_w = 4;
    // one word per address
    localparam int mem_depth = 1 << addr_w;

    // unlisted codes fall through the decoder as NOP
    typedef enum logic [3:0] {
        NOP = 4'h0,
        LDA = 4'h1,
        ADD = 4'h2,
        SUB = 4'h3,
        STA = 4'h4,
        LDI = 4'h5,
        JMP = 4'h6,
        JC  = 4'h7,
        JZ  = 4'h8,
        OUT = 4'hE,
        HLT = 4'hF
    } opcode_t;

    // opcode in the high nibble, operand in the low nibble
    typedef struct packed {
        opcode_t             opcode;
        logic [addr_w-1:0]   operand;
    } instr_t;

    // a memory word is fetched as an instruction or read as plain data
    typedef union packed {
        instr_t              instr;
        logic [data_w-1:0]   data;
    } mem_word_u;

endpackage

`default_nettype wire
